//--- hw/asym_ram_macros.svh
/*
 * asymmetric RAM sizing: port widths, depth, lane count and byte order
 */
`ifndef ASYM_RAM_MACROS_SVH
`define ASYM_RAM_MACROS_SVH

// write port carries whole words
`define ASYM_W_DATA_W 32

// read port returns single bytes
`define ASYM_R_DATA_W 8

// width ratio, one byte-wide memory per lane
`define ASYM_LANES 4

// byte select field taken from the low read address bits
`define ASYM_LANE_SEL_W 2

// word address, 256 words deep
`define ASYM_W_ADDR_W 8

// byte address, word address plus byte select
`define ASYM_R_ADDR_W 10

// 0: select k returns word bits k*8 upward
// 1: select k returns lane 3-k
`define ASYM_BIG_ENDIAN 0

`endif

//--- hw/asym_ram_pkg.sv
/*
 * asymmetric RAM types
 * port requests, per-lane controls and data word types
 */
`include "asym_ram_macros.svh"

package asym_ram_pkg;

   // data types of the two ports
   typedef logic [`ASYM_W_DATA_W-1:0] w_word_t;
   typedef logic [`ASYM_R_DATA_W-1:0] r_byte_t;

   // byte position inside a word
   typedef logic [`ASYM_LANE_SEL_W-1:0] lane_sel_t;

   // one write port request, full word
   typedef struct packed {
      logic                      en;
      logic [`ASYM_W_ADDR_W-1:0] addr;
      w_word_t                   data;
   } wr_req_t;

   // one read port request, byte address
   typedef struct packed {
      logic                      en;
      logic [`ASYM_R_ADDR_W-1:0] addr;
   } rd_req_t;

   // write control seen by a single lane
   typedef struct packed {
      logic                      en;
      logic [`ASYM_W_ADDR_W-1:0] addr;
      r_byte_t                   data;
   } lane_wr_t;

   // read control seen by a single lane
   typedef struct packed {
      logic                      en;
      logic [`ASYM_W_ADDR_W-1:0] addr;
   } lane_rd_t;

endpackage

//--- hw/asym_lane_ram.sv
/*
 * asymmetric RAM lane: byte-wide dual-port memory
 * one write port, one read port with registered read-first output
 */
`timescale 1ns/1ps
`include "asym_ram_macros.svh"

module asym_lane_ram
   import asym_ram_pkg::*;
(
   input  logic     clk_i,
   input  lane_wr_t lane_wr_i,
   input  lane_rd_t lane_rd_i,
   output r_byte_t  lane_data_o
);

   localparam int unsigned DEPTH = 1 << `ASYM_W_ADDR_W;

   // storage, contents survive reset
   r_byte_t mem [DEPTH];

   // read data register
   r_byte_t rd_data_q;

   // write port
   always_ff @(posedge clk_i) begin
      if (lane_wr_i.en) begin
         mem[lane_wr_i.addr] <= lane_wr_i.data;
      end
   end

   // read port
   // a same-edge write is not yet in mem, so the old byte is returned
   always_ff @(posedge clk_i) begin
      if (lane_rd_i.en) begin
         rd_data_q <= mem[lane_rd_i.addr];
      end
   end

   // without a read enable the last value stays
   assign lane_data_o = rd_data_q;

endmodule

//--- hw/asym_port_decode.sv
/*
 * asymmetric RAM port decoder
 * fans the write word out to the lanes, makes a one-hot lane read enable
 */
`timescale 1ns/1ps
`include "asym_ram_macros.svh"

module asym_port_decode
   import asym_ram_pkg::*;
(
   input  wr_req_t                       wr_req_i,
   input  rd_req_t                       rd_req_i,
   output lane_wr_t [`ASYM_LANES-1:0]    lane_wr_o,
   output lane_rd_t [`ASYM_LANES-1:0]    lane_rd_o
);

   localparam int unsigned SEL_W  = `ASYM_LANE_SEL_W;
   localparam int unsigned BYTE_W = `ASYM_R_DATA_W;

   // byte select from the read address
   lane_sel_t rd_sel;

   // lane holding the addressed byte
   lane_sel_t rd_lane;

   // word address shared by all lanes
   logic [`ASYM_W_ADDR_W-1:0] rd_word_addr;

   // one-hot read enable
   logic [`ASYM_LANES-1:0] rd_en_onehot;

   assign rd_sel       = rd_req_i.addr[SEL_W-1:0];
   assign rd_word_addr = rd_req_i.addr[`ASYM_R_ADDR_W-1:SEL_W];

   generate
      if (`ASYM_BIG_ENDIAN) begin : g_big_endian
         // lowest select picks the top lane
         assign rd_lane = ~rd_sel;
      end else begin : g_little_endian
         assign rd_lane = rd_sel;
      end
   endgenerate

   assign rd_en_onehot = {{(`ASYM_LANES - 1) {1'b0}}, rd_req_i.en} << rd_lane;

   // write side, every lane stores its own byte of the word
   always_comb begin
      for (int k = 0; k < `ASYM_LANES; k++) begin
         lane_wr_o[k].en   = wr_req_i.en;
         lane_wr_o[k].addr = wr_req_i.addr;
         lane_wr_o[k].data = wr_req_i.data[k*BYTE_W+:BYTE_W];
      end
   end

   // read side, only the addressed lane is enabled
   always_comb begin
      for (int k = 0; k < `ASYM_LANES; k++) begin
         lane_rd_o[k].en   = rd_en_onehot[k];
         lane_rd_o[k].addr = rd_word_addr;
      end
   end

endmodule

//--- hw/asym_read_gather.sv
/*
 * asymmetric RAM read gather
 * picks the addressed byte from the lanes and holds it between reads
 */
`timescale 1ns/1ps
`include "asym_ram_macros.svh"

module asym_read_gather
   import asym_ram_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  rd_req_t                     rd_req_i,
   input  r_byte_t [`ASYM_LANES-1:0]   lane_data_i,
   output r_byte_t                     r_data_o
);

   localparam int unsigned SEL_W = `ASYM_LANE_SEL_W;

   // lane data is fresh in the cycle after a read
   logic valid_q;

   // byte select of the last read
   lane_sel_t sel_q;

   // last returned byte
   r_byte_t hold_q;

   // lane index for the registered select
   lane_sel_t lane_idx;

   // byte taken from the lanes
   r_byte_t picked;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= rd_req_i.en;
      end
   end

   // only updated on a read, so it lines up with the lane register
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sel_q <= '0;
      end else if (rd_req_i.en) begin
         sel_q <= rd_req_i.addr[SEL_W-1:0];
      end
   end

   generate
      if (`ASYM_BIG_ENDIAN) begin : g_big_endian
         assign lane_idx = ~sel_q;
      end else begin : g_little_endian
         assign lane_idx = sel_q;
      end
   endgenerate

   assign picked = lane_data_i[lane_idx];

   // capture the byte while it is valid
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         hold_q <= '0;
      end else if (valid_q) begin
         hold_q <= picked;
      end
   end

   // bypass on the read cycle, hold afterwards
   always_comb begin
      if (valid_q) begin
         r_data_o = picked;
      end else begin
         r_data_o = hold_q;
      end
   end

endmodule

//--- hw/asym_ram.sv
/*
 * asymmetric-width dual-port RAM
 * 32-bit word write port, 8-bit byte read port, four byte-wide lanes
 */
`timescale 1ns/1ps
`include "asym_ram_macros.svh"

module asym_ram
   import asym_ram_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,
   input  wr_req_t wr_req_i,
   input  rd_req_t rd_req_i,
   output r_byte_t r_data_o
);

   // per-lane controls from the decoder
   lane_wr_t [`ASYM_LANES-1:0] lane_wr;
   lane_rd_t [`ASYM_LANES-1:0] lane_rd;

   // registered lane outputs
   r_byte_t [`ASYM_LANES-1:0] lane_data;

   asym_port_decode asym_port_decode_inst (
      .wr_req_i (wr_req_i),
      .rd_req_i (rd_req_i),
      .lane_wr_o(lane_wr),
      .lane_rd_o(lane_rd)
   );

   // one byte-wide memory per lane
   for (genvar k = 0; k < `ASYM_LANES; k++) begin : g_lane
      asym_lane_ram asym_lane_ram_inst (
         .clk_i      (clk_i),
         .lane_wr_i  (lane_wr[k]),
         .lane_rd_i  (lane_rd[k]),
         .lane_data_o(lane_data[k])
      );
   end

   asym_read_gather asym_read_gather_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rd_req_i   (rd_req_i),
      .lane_data_i(lane_data),
      .r_data_o   (r_data_o)
   );

endmodule

//--- dv/asym_ram_tb.sv
/*
 * asymmetric RAM testbench with random word writes and byte reads
 * checked against a word-array model with read-first ordering
 */
`timescale 1ns/1ps
`include "asym_ram_macros.svh"

module asym_ram_tb
   import asym_ram_pkg::*;
();

   localparam int unsigned N_WORDS    = 1 << `ASYM_W_ADDR_W;
   localparam int unsigned N_BYTES    = 1 << `ASYM_R_ADDR_W;
   localparam int unsigned N_HOLD     = 40;
   localparam int unsigned N_MIXED    = 2000;
   localparam int unsigned N_READBACK = 64;

   // reset, fill, sweep, hold rounds of up to 6 cycles, mixed, reset, readback
   localparam int unsigned CYCLE_LIMIT = 4 + 1 + N_WORDS + N_BYTES + 1
                                       + N_HOLD * 6 + N_MIXED + 1
                                       + 4 + 1 + N_READBACK + 1 + 100;

   logic    clk_i;
   logic    rst_i;
   wr_req_t wr_req_i;
   rd_req_t rd_req_i;
   r_byte_t r_data_o;

   // reference model
   w_word_t model_mem [N_WORDS];
   r_byte_t exp_q [$];
   r_byte_t last_exp;

   int unsigned cycle_count;

   asym_ram asym_ram_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .wr_req_i(wr_req_i),
      .rd_req_i(rd_req_i),
      .r_data_o(r_data_o)
   );

   initial begin
      clk_i = 1'b0;
   end

   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("TIMEOUT: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Something failed");
         $fatal(1, "simulation stopped by the cycle limit");
      end
   end

   // byte of a word for a given select under the byte order rule
   function automatic r_byte_t expected_byte(w_word_t word, lane_sel_t sel);
      int unsigned idx;
      if (`ASYM_BIG_ENDIAN) begin
         idx = `ASYM_LANES - 1 - sel;
      end else begin
         idx = sel;
      end
      return word[idx*`ASYM_R_DATA_W +: `ASYM_R_DATA_W];
   endfunction

   function automatic wr_req_t rand_write(logic en);
      wr_req_t     req;
      logic [31:0] r;
      r        = $urandom;
      req.en   = en;
      req.addr = r[`ASYM_W_ADDR_W-1:0];
      req.data = $urandom;
      return req;
   endfunction

   function automatic rd_req_t rand_read(logic en);
      rd_req_t     req;
      logic [31:0] r;
      r        = $urandom;
      req.en   = en;
      req.addr = r[`ASYM_R_ADDR_W-1:0];
      return req;
   endfunction

   task automatic check_byte(r_byte_t expected, r_byte_t actual, string name);
      if (actual !== expected) begin
         $display("MISMATCH time=%0t signal=%s expected=%02h actual=%02h",
                  $time, name, expected, actual);
         $display("Something failed");
         $fatal(1, "stopping at the first error");
      end
   endtask

   task automatic check_reset_state();
      r_byte_t zero;
      zero = '0;
      if (r_data_o !== zero) begin
         $display("MISMATCH time=%0t signal=r_data_o (after reset) expected=%02h actual=%02h",
                  $time, zero, r_data_o);
         $display("Something failed");
         $fatal(1, "stopping at the first error");
      end
   endtask

   // byte of last cycle's read or else the held byte
   task automatic expect_output();
      r_byte_t exp;
      if (exp_q.size() > 0) begin
         exp      = exp_q.pop_front();
         last_exp = exp;
      end else begin
         exp = last_exp;
      end
      check_byte(exp, r_data_o, "r_data_o");
   endtask

   // check the output for one cycle and drive the next requests
   task automatic step(wr_req_t wr, rd_req_t rd);
      logic [`ASYM_W_ADDR_W-1:0] word_addr;
      lane_sel_t                 sel;
      @(negedge clk_i);
      expect_output();
      word_addr = rd.addr[`ASYM_R_ADDR_W-1:`ASYM_LANE_SEL_W];
      sel       = rd.addr[`ASYM_LANE_SEL_W-1:0];
      // read sees the word before this edge's write
      if (rd.en) begin
         exp_q.push_back(expected_byte(model_mem[word_addr], sel));
      end
      if (wr.en) begin
         model_mem[wr.addr] = wr.data;
      end
      wr_req_i = wr;
      rd_req_i = rd;
   endtask

   task automatic reset_dut();
      rst_i    = 1'b1;
      wr_req_i = '0;
      rd_req_i = '0;
      repeat (4) @(negedge clk_i);
      rst_i    = 1'b0;
      last_exp = '0;
      exp_q.delete();
      @(negedge clk_i);
      check_reset_state();
   endtask

   initial begin
      wr_req_t                   wr;
      rd_req_t                   rd;
      wr_req_t                   idle_wr;
      rd_req_t                   idle_rd;
      logic [31:0]               r;
      logic [`ASYM_W_ADDR_W-1:0] word_read;
      int unsigned               n_idle;

      rst_i       = 1'b1;
      wr_req_i    = '0;
      rd_req_i    = '0;
      cycle_count = 0;
      last_exp    = '0;
      idle_wr     = '0;
      idle_rd     = '0;
      void'($urandom(81));

      reset_dut();

      // fill every word, then sweep all byte addresses back to back
      for (int unsigned i = 0; i < N_WORDS; i++) begin
         wr      = rand_write(1'b1);
         wr.addr = i[`ASYM_W_ADDR_W-1:0];
         step(wr, idle_rd);
      end
      for (int unsigned i = 0; i < N_BYTES; i++) begin
         rd.en   = 1'b1;
         rd.addr = i[`ASYM_R_ADDR_W-1:0];
         step(idle_wr, rd);
      end
      step(idle_wr, idle_rd);

      // a read followed by idle cycles with writes to the word just read
      for (int unsigned h = 0; h < N_HOLD; h++) begin
         rd        = rand_read(1'b1);
         word_read = rd.addr[`ASYM_R_ADDR_W-1:`ASYM_LANE_SEL_W];
         step(rand_write(1'b0), rd);
         n_idle = $urandom_range(1, 5);
         for (int unsigned j = 0; j < n_idle; j++) begin
            wr = rand_write(1'b1);
            if (j == 0) begin
               wr.addr = word_read;
            end
            step(wr, idle_rd);
         end
      end

      // mixed traffic with some writes colliding with the read word
      for (int unsigned i = 0; i < N_MIXED; i++) begin
         r  = $urandom;
         rd = rand_read(r[0]);
         wr = rand_write(r[1]);
         if (rd.en && wr.en && (r[4:2] == 3'd0)) begin
            wr.addr = rd.addr[`ASYM_R_ADDR_W-1:`ASYM_LANE_SEL_W];
         end
         step(wr, rd);
      end
      step(idle_wr, idle_rd);

      // reset mid-run and read back the surviving memory contents
      reset_dut();
      for (int unsigned i = 0; i < N_READBACK; i++) begin
         step(idle_wr, rand_read(1'b1));
      end
      step(idle_wr, idle_rd);

      $display("Everything OK");
      $finish;
   end

endmodule

//--- sim.f
+incdir+hw
hw/asym_ram_pkg.sv
hw/asym_lane_ram.sv
hw/asym_port_decode.sv
hw/asym_read_gather.sv
hw/asym_ram.sv
dv/asym_ram_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the asymmetric RAM testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f sim.f --top-module asym_ram_tb -o asym_ram_sim

# the log is searched for the result below
./obj_dir/asym_ram_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
   echo "simulation reported a failure"
   exit 1
fi

if ! grep -q "Everything OK" "$LOG"; then
   echo "simulation ended without a result"
   exit 1
fi

echo "simulation passed"
